// ==== design/busCtrl_macros.svh ====
`ifndef BUSCTRL_MACROS_SVH
`define BUSCTRL_MACROS_SVH

////////////////////////////////////////
// ROM timing
////////////////////////////////////////

// CLK40 wait cycles between the transfer start and the ROM taN
`define ROM_TA_DELAY 3

////////////////////////////////////////
// Space bases, matched against addr[31:20]
////////////////////////////////////////

// Kickstart ROM at 0x00F00000
`define ROM_BASE 12'h00F
// Boot overlay window at address zero
`define OVL_TOP 12'h000
// CIA space at 0x00B00000
`define CIA_BASE 12'h00B
// Custom chip registers at 0x00D00000
`define CHIPREG_BASE 12'h00D
// Autoconfig at 0x00E00000
`define AUTOCONFIG_BASE 12'h00E

`endif

// ==== design/busCtrlPkg.sv ====
`default_nettype none

package busCtrlPkg;

    ////////////////////////////////////////
    // Address space flags
    ////////////////////////////////////////

    // One flag per decoded space
    // At most one is set for a given address
    typedef struct packed {
        // Kickstart ROM, or the low window while overlay is on
        logic romSpace;
        // First two megabytes, shared with the chipset DMA
        logic chipRamSpace;
        // Custom chip registers
        logic chipRegSpace;
        // Both CIAs, slow TTL bus
        logic ciaSpace;
        // Zorro style autoconfig window
        logic autoConfigSpace;
    } busSpace_t;

    ////////////////////////////////////////
    // Acknowledge sequencer
    ////////////////////////////////////////

    // Idle, count the ROM setup, pull taN low, force it high
    typedef enum logic [1:0] {
        ACK_IDLE,
        ACK_WAIT,
        ACK_DRIVE,
        ACK_NEGATE
    } ackState_t;

endpackage

`default_nettype wire

// ==== design/cycleTracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module cycleTracker (
    input  logic CLK40,
    input  logic TS_RESET,
    // Transfer start from the 68040, low for one clock only
    input  logic tsN,
    // Any slave acknowledge on the shared taN line
    input  logic ackSeen,
    output logic cycleActive
);

    ////////////////////////////////////////
    // Transfer start capture
    ////////////////////////////////////////

    // tsN is a single clock pulse
    // tipN would stay low across back to back cycles
    // so it cannot mark the start of a new one
    // Keep the start until some slave ends the cycle

    always_ff @(posedge CLK40 or posedge TS_RESET) begin
        if (TS_RESET) begin
            cycleActive <= 1'b0;
        end else if (ackSeen) begin
            // Acknowledge wins over a start in the same clock
            cycleActive <= 1'b0;
        end else if (!tsN) begin
            cycleActive <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/addressDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "busCtrl_macros.svh"

module addressDecode import busCtrlPkg::*; (
    // Upper address bits only, the rest go straight to the chips
    input  logic [31:20] addr,
    // Boot overlay from the CIA port
    input  logic         ovl,
    output busSpace_t    space
);

    logic ovlWindow;
    logic ovlHit;
    logic chipRamHit;

    ////////////////////////////////////////
    // Window compares
    ////////////////////////////////////////

    // Low window that the ROM covers at boot
    assign ovlWindow = (addr == `OVL_TOP);

    // Overlay maps ROM over the low window
    // so the reset vectors come from Kickstart
    assign ovlHit = ovl && ovlWindow;

    // Chip RAM spans the first two megabytes
    assign chipRamHit = (addr[31:21] == 11'h000);

    ////////////////////////////////////////
    // Space flags
    ////////////////////////////////////////

    always_comb begin
        space = '0;

        // ROM at its own base, or at zero while overlaid
        space.romSpace = (addr == `ROM_BASE) || ovlHit;

        // Chip RAM only shows once the overlay is dropped
        space.chipRamSpace = chipRamHit && !ovlHit;

        // Chipset registers and CIAs
        space.chipRegSpace = (addr == `CHIPREG_BASE);
        space.ciaSpace     = (addr == `CIA_BASE);

        // Expansion boards configure here
        space.autoConfigSpace = (addr == `AUTOCONFIG_BASE);
    end

endmodule

`default_nettype wire

// ==== design/transferAck.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "busCtrl_macros.svh"

module transferAck import busCtrlPkg::*; (
    input  logic      CLK40,
    input  logic      TS_RESET,
    input  logic      cycleActive,
    input  busSpace_t space,
    // Shared with the other slaves, pulled up on the board
    inout  wire       taN,
    output logic      tbiN,
    output logic      tciN,
    output logic      romEnN,
    output logic      bufEnN,
    // Resolved line level back to the start capture
    output logic      ackSeen
);

    // Counter wide enough to reach the ROM delay
    localparam int delayW =
        ($clog2(`ROM_TA_DELAY + 1) > 0) ? $clog2(`ROM_TA_DELAY + 1) : 1;
    localparam logic [delayW-1:0] delayLast = delayW'(`ROM_TA_DELAY);

    ackState_t         ackState;
    logic [delayW-1:0] delayCnt;
    logic              romStart;
    logic              driveLow;
    logic              driveHigh;

    ////////////////////////////////////////
    // ROM acknowledge sequencer
    ////////////////////////////////////////

    // Only ROM cycles are answered here
    assign romStart = cycleActive && space.romSpace;

    // Hold off taN for the ROM setup time
    // then pull low for one clock and force high for one more
    // A slowly rising line would otherwise end the next cycle early
    always_ff @(posedge CLK40 or posedge TS_RESET) begin
        if (TS_RESET) begin
            ackState <= ACK_IDLE;
            delayCnt <= '0;
        end else begin
            case (ackState)
                ACK_IDLE: begin
                    if (romStart) begin
                        delayCnt <= delayW'(1);
                        ackState <= (`ROM_TA_DELAY == 0) ? ACK_DRIVE : ACK_WAIT;
                    end
                end
                ACK_WAIT: begin
                    if (delayCnt == delayLast) begin
                        ackState <= ACK_DRIVE;
                    end else begin
                        delayCnt <= delayCnt + 1'b1;
                    end
                end
                ACK_DRIVE:  ackState <= ACK_NEGATE;
                ACK_NEGATE: ackState <= ACK_IDLE;
                default:    ackState <= ACK_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // Bus outputs
    ////////////////////////////////////////

    assign driveLow  = (ackState == ACK_DRIVE);
    assign driveHigh = (ackState == ACK_NEGATE);

    // Released whenever another slave may own the line
    assign taN = driveLow ? 1'b0 : (driveHigh ? 1'b1 : 1'bz);
    assign ackSeen = (taN == 1'b0);

    // No bursts from any space this block answers
    assign tbiN = !driveLow;

    // Agnus writes chip RAM behind the CPU, so never cache it
    assign tciN = !(driveLow && space.chipRamSpace);

    assign romEnN = !space.romSpace;

    // Data buffers for the LVTTL side only
    // ROM and CIA sit on the TTL side
    assign bufEnN = !(cycleActive &&
        (space.chipRamSpace || space.chipRegSpace || space.autoConfigSpace));

endmodule

`default_nettype wire

// ==== design/tickClocks.sv ====
`timescale 1ns/1ps
`default_nettype none

module tickClocks #(
    // 40 MHz down to 60 Hz
    parameter int TICK60_DIV = 666667,
    // 40 MHz down to 50 Hz
    parameter int TICK50_DIV = 800000,
    // Clocks per CIA phase, ten phases per CIA period
    parameter int CIA_STEP   = 6
) (
    input  logic CLK40,
    input  logic TS_RESET,
    output logic tick60,
    output logic tick50,
    output logic ciaClk
);

    ////////////////////////////////////////
    // Tick pulses
    ////////////////////////////////////////

    localparam int tickDiv [2] = '{TICK60_DIV, TICK50_DIV};

    // Same divider twice, index 0 is 60 Hz and 1 is 50 Hz
    for (genvar i = 0; i < 2; i++) begin : gTick
        localparam int cntW = (tickDiv[i] > 1) ? $clog2(tickDiv[i]) : 1;
        localparam logic [cntW-1:0] cntLast = cntW'(tickDiv[i] - 1);

        logic [cntW-1:0] tickCnt;
        logic            tickOut;

        // One clock pulse on the last count
        always_ff @(posedge CLK40 or posedge TS_RESET) begin
            if (TS_RESET) begin
                tickCnt <= '0;
                tickOut <= 1'b0;
            end else if (tickCnt == cntLast) begin
                tickCnt <= '0;
                tickOut <= 1'b1;
            end else begin
                tickCnt <= tickCnt + 1'b1;
                tickOut <= 1'b0;
            end
        end
    end

    assign tick60 = gTick[0].tickOut;
    assign tick50 = gTick[1].tickOut;

    ////////////////////////////////////////
    // CIA clock
    ////////////////////////////////////////

    localparam int stepW = (CIA_STEP > 1) ? $clog2(CIA_STEP) : 1;
    localparam logic [stepW-1:0] stepLast = stepW'(CIA_STEP - 1);
    // Phases 0 to 5 low, 6 to 9 high, like the E clock
    localparam logic [3:0] ciaLastPhase = 4'd9;
    localparam logic [3:0] ciaHighPhase = 4'd6;

    logic [stepW-1:0] stepCnt;
    logic [3:0]       ciaPhase;
    logic [3:0]       phaseNext;

    assign phaseNext = (ciaPhase == ciaLastPhase) ? 4'd0 : ciaPhase + 4'd1;

    // Output is a flop, so no glitches reach the CIAs
    always_ff @(posedge CLK40 or posedge TS_RESET) begin
        if (TS_RESET) begin
            stepCnt  <= '0;
            ciaPhase <= 4'd0;
            ciaClk   <= 1'b0;
        end else if (stepCnt == stepLast) begin
            stepCnt  <= '0;
            ciaPhase <= phaseNext;
            ciaClk   <= (phaseNext >= ciaHighPhase);
        end else begin
            stepCnt <= stepCnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/busCtrlTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module busCtrlTop import busCtrlPkg::*; #(
    parameter int TICK60_DIV = 666667,
    parameter int TICK50_DIV = 800000,
    parameter int CIA_STEP   = 6
) (
    input  logic        CLK40,
    input  logic        TS_RESET,
    input  logic        tsN,
    input  logic        ovl,
    // Low bits reach the chips directly, only 31:20 are decoded
    input  logic [31:1] addr,
    inout  wire         taN,
    output logic        tbiN,
    output logic        tciN,
    output logic        romEnN,
    output logic        bufEnN,
    output logic        tick60,
    output logic        tick50,
    output logic        ciaClk
);

    busSpace_t space;
    logic      cycleActive;
    logic      ackSeen;

    ////////////////////////////////////////
    // 68040 bus side
    ////////////////////////////////////////

    cycleTracker uCycleTracker (
        .CLK40       (CLK40),
        .TS_RESET    (TS_RESET),
        .tsN         (tsN),
        .ackSeen     (ackSeen),
        .cycleActive (cycleActive)
    );

    addressDecode uAddressDecode (
        .addr  (addr[31:20]),
        .ovl   (ovl),
        .space (space)
    );

    transferAck uTransferAck (
        .CLK40       (CLK40),
        .TS_RESET    (TS_RESET),
        .cycleActive (cycleActive),
        .space       (space),
        .taN         (taN),
        .tbiN        (tbiN),
        .tciN        (tciN),
        .romEnN      (romEnN),
        .bufEnN      (bufEnN),
        .ackSeen     (ackSeen)
    );

    ////////////////////////////////////////
    // Timer ticks and CIA clock
    ////////////////////////////////////////

    // Replaces the separate 6 and 7 MHz oscillators
    tickClocks #(
        .TICK60_DIV (TICK60_DIV),
        .TICK50_DIV (TICK50_DIV),
        .CIA_STEP   (CIA_STEP)
    ) uTickClocks (
        .CLK40    (CLK40),
        .TS_RESET (TS_RESET),
        .tick60   (tick60),
        .tick50   (tick50),
        .ciaClk   (ciaClk)
    );

endmodule

`default_nettype wire

// ==== tests/busCtrl_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module busCtrl_properties (
    input wire CLK40,
    input wire TS_RESET,
    // Resolved line level, pull-up included
    input wire taN,
    input wire tbiN,
    input wire tick60,
    input wire tick50
);

    // Failed assertions, read by the testbench for its verdict
    int propFails = 0;

    ////////////////////////////////////////
    // Acknowledge line
    ////////////////////////////////////////

    // Any slave holds taN low for a single clock
    assert property (@(posedge CLK40) disable iff (TS_RESET) !taN |=> taN)
        else begin
            $error("taN stayed low for more than one clock");
            propFails++;
        end

    // Burst inhibit only alongside our own acknowledge
    assert property (@(posedge CLK40) disable iff (TS_RESET) !tbiN |-> !taN)
        else begin
            $error("tbiN low while taN is not low");
            propFails++;
        end

    ////////////////////////////////////////
    // Tick pulses
    ////////////////////////////////////////

    assert property (@(posedge CLK40) disable iff (TS_RESET)
        (tick60 |=> !tick60) and (tick50 |=> !tick50))
        else begin
            $error("Tick pulse wider than one clock");
            propFails++;
        end

endmodule

// Watch the top level ports of every busCtrlTop
bind busCtrlTop busCtrl_properties uProps (
    .CLK40    (CLK40),
    .TS_RESET (TS_RESET),
    .taN      (taN),
    .tbiN     (tbiN),
    .tick60   (tick60),
    .tick50   (tick50)
);

`default_nettype wire

// ==== tests/busCtrlTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "busCtrl_macros.svh"

module busCtrlTb;

    // Small dividers so the tick test stays short
    localparam int tick60Div = 20;
    localparam int tick50Div = 24;
    localparam int ciaStep   = 2;
    localparam int ackLimit  = 20;

    logic        CLK40;
    logic        TS_RESET;
    logic        tsN;
    logic        ovl;
    logic [31:1] addr;
    logic        slaveTaLow;
    wire         taN;
    logic        tbiN;
    logic        tciN;
    logic        romEnN;
    logic        bufEnN;
    logic        tick60;
    logic        tick50;
    logic        ciaClk;

    int errCount;
    int checkCount;
    int testCount;

    // Board pull-up, plus the other slave on the shared line
    pullup (taN);
    assign taN = slaveTaLow ? 1'b0 : 1'bz;

    busCtrlTop #(
        .TICK60_DIV (tick60Div),
        .TICK50_DIV (tick50Div),
        .CIA_STEP   (ciaStep)
    ) u_dut (
        .CLK40    (CLK40),
        .TS_RESET (TS_RESET),
        .tsN      (tsN),
        .ovl      (ovl),
        .addr     (addr),
        .taN      (taN),
        .tbiN     (tbiN),
        .tciN     (tciN),
        .romEnN   (romEnN),
        .bufEnN   (bufEnN),
        .tick60   (tick60),
        .tick50   (tick50),
        .ciaClk   (ciaClk)
    );

    always #5 CLK40 = ~CLK40;

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic expectEq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        checkCount++;
        assert (got === exp) else begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            errCount++;
        end
    endtask

    task automatic reportTest(input string name, input int errBefore);
        testCount++;
        $display("%-14s %s", name, (errCount == errBefore) ? "passed" : "failed");
    endtask

    // tsN low for one clock, sampled at the second edge here
    task automatic startTransfer(input logic [31:0] byteAddr, input logic ovlLevel);
        @(posedge CLK40);
        addr <= byteAddr[31:1];
        ovl  <= ovlLevel;
        tsN  <= 1'b0;
        @(posedge CLK40);
        tsN  <= 1'b1;
    endtask

    // Counts edges after the tsN edge until taN reads low
    task automatic waitAckLow(input int limit, output int edges, output bit seen);
        edges = 0;
        seen  = 1'b0;
        while (!seen && edges < limit) begin
            @(posedge CLK40);
            edges++;
            @(negedge CLK40);
            seen = (taN === 1'b0);
        end
    endtask

    // Plays the slave that owns the space, then waits for the buffers to close
    task automatic otherSlaveAck;
        int cycles;
        cycles = 0;
        @(posedge CLK40);
        slaveTaLow <= 1'b1;
        @(posedge CLK40);
        slaveTaLow <= 1'b0;
        @(negedge CLK40);
        while (bufEnN !== 1'b1 && cycles < 4) begin
            @(negedge CLK40);
            cycles++;
        end
        expectEq("bufEnN", bufEnN, 1'b1);
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic resetState;
        int errBefore;
        errBefore = errCount;
        @(negedge CLK40);
        expectEq("taN", taN, 1'b1);
        expectEq("tbiN", tbiN, 1'b1);
        expectEq("tciN", tciN, 1'b1);
        expectEq("romEnN", romEnN, 1'b1);
        expectEq("bufEnN", bufEnN, 1'b1);
        expectEq("tick60", tick60, 1'b0);
        expectEq("tick50", tick50, 1'b0);
        expectEq("ciaClk", ciaClk, 1'b0);
        reportTest("resetState", errBefore);
    endtask

    task automatic romAck;
        int          errBefore;
        int          edges;
        bit          seen;
        logic [31:0] offset;
        errBefore = errCount;
        offset = $urandom() & 32'h000F_FFFE;
        startTransfer({`ROM_BASE, 20'h0} | offset, 1'b0);
        @(negedge CLK40);
        expectEq("romEnN", romEnN, 1'b0);
        waitAckLow(ackLimit, edges, seen);
        assert (seen) else begin
            $display("ROM cycle got no acknowledge within %0d clocks", ackLimit);
            errCount++;
        end
        // Setup delay, then one edge to reach the drive state
        expectEq("ackEdges", edges, `ROM_TA_DELAY + 1);
        expectEq("tbiN", tbiN, 1'b0);
        expectEq("tciN", tciN, 1'b1);
        // Negate clock
        @(negedge CLK40);
        expectEq("taN", taN, 1'b1);
        expectEq("tbiN", tbiN, 1'b1);
        repeat (2) @(negedge CLK40);
        expectEq("taN", taN, 1'b1);
        reportTest("romAck", errBefore);
    endtask

    task automatic overlayWindow;
        int          errBefore;
        int          edges;
        bit          seen;
        logic [31:0] lowAddr;
        errBefore = errCount;
        lowAddr = {`OVL_TOP, 20'h0} | ($urandom() & 32'h000F_FFFE);
        // Boot fetch, ROM answers at zero
        startTransfer(lowAddr, 1'b1);
        @(negedge CLK40);
        expectEq("romEnN", romEnN, 1'b0);
        waitAckLow(ackLimit, edges, seen);
        assert (seen) else begin
            $display("Overlaid fetch got no acknowledge within %0d clocks", ackLimit);
            errCount++;
        end
        repeat (3) @(posedge CLK40);
        // Overlay off, same address is chip RAM now
        startTransfer(lowAddr, 1'b0);
        @(negedge CLK40);
        expectEq("romEnN", romEnN, 1'b1);
        waitAckLow(ackLimit, edges, seen);
        assert (!seen) else begin
            $display("taN driven low for chip RAM with the overlay off");
            errCount++;
        end
        expectEq("romEnN", romEnN, 1'b1);
        otherSlaveAck();
        reportTest("overlayWindow", errBefore);
    endtask

    task automatic chipRegCycle;
        int errBefore;
        int cycles;
        int lowCount;
        errBefore = errCount;
        lowCount = 0;
        startTransfer({`CHIPREG_BASE, 20'h0} | ($urandom() & 32'h000F_FFFE), 1'b0);
        @(negedge CLK40);
        expectEq("bufEnN", bufEnN, 1'b0);
        for (cycles = 0; cycles < 10; cycles++) begin
            @(negedge CLK40);
            if (taN === 1'b0) begin
                lowCount++;
            end
        end
        assert (lowCount == 0) else begin
            $display("DUT pulled taN low during a chip register cycle");
            errCount++;
        end
        expectEq("bufEnN", bufEnN, 1'b0);
        otherSlaveAck();
        reportTest("chipRegCycle", errBefore);
    endtask

    task automatic tickCounts;
        int   errBefore;
        int   n60;
        int   n50;
        int   runLen;
        int   runs;
        bit   seenEdge;
        logic prevCia;
        errBefore = errCount;
        n60 = 0;
        n50 = 0;
        runs = 0;
        seenEdge = 1'b0;
        @(negedge CLK40);
        prevCia = ciaClk;
        runLen = 1;
        for (int i = 0; i < 240; i++) begin
            @(negedge CLK40);
            n60 += tick60;
            n50 += tick50;
            if (ciaClk !== prevCia) begin
                // Only whole runs, the first one started mid phase
                if (seenEdge) begin
                    expectEq(prevCia ? "ciaClk high run" : "ciaClk low run", runLen,
                             prevCia ? 4 * ciaStep : 6 * ciaStep);
                    runs++;
                end
                seenEdge = 1'b1;
                runLen = 1;
                prevCia = ciaClk;
            end else begin
                runLen++;
            end
        end
        expectEq("tick60 count", n60, 240 / tick60Div);
        expectEq("tick50 count", n50, 240 / tick50Div);
        assert (runs >= 2) else begin
            $display("ciaClk did not complete a full period in 240 clocks");
            errCount++;
        end
        reportTest("tickCounts", errBefore);
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        CLK40      = 1'b0;
        TS_RESET   = 1'b1;
        tsN        = 1'b1;
        ovl        = 1'b0;
        addr       = '0;
        slaveTaLow = 1'b0;
        errCount   = 0;
        checkCount = 0;
        testCount  = 0;
        void'($urandom(32'hd9f8_c1af));

        repeat (10) @(posedge CLK40);
        TS_RESET <= 1'b0;

        resetState();
        romAck();
        overlayWindow();
        chipRegCycle();
        tickCounts();

        errCount += u_dut.uProps.propFails;
        $display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
        if (errCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+design
design/busCtrlPkg.sv
design/cycleTracker.sv
design/addressDecode.sv
design/transferAck.sv
design/tickClocks.sv
design/busCtrlTop.sv
tests/busCtrl_properties.sv
tests/busCtrlTb.sv
